//--- hdl/mvp_cfg_pkg.sv
/*
 * mvp configuration package
 * legal limits of the job registers, region size multipliers,
 * and the error and status words reported to the host
 */
package mvp_cfg_pkg;

    // limits of the five job registers
    localparam int LEVEL_MAX     = 12;
    localparam int COL_SIZE_MAX  = 16384;
    localparam int MIN_MAT_ELEMS = 8192;
    localparam int SPLIT_MAX     = 4;
    localparam int INDEX_BITS    = 13;
    localparam int MAT_LEN_BITS  = 15;

    // region size per unit of mat_len and of split
    localparam logic [31:0] MAT_BYTES_PER_LEN   = 32'h0001_8000;
    localparam logic [31:0] VEC_BYTES_PER_SPLIT = 32'h0003_0000;

    // one flag per rule, level in bit 0
    typedef struct packed {
        logic mat_len;
        logic index;
        logic split;
        logic col_size;
        logic level;
    } cfg_err_t;

    // host status word, done in bit 0 and errors at 12:8
    typedef struct packed {
        logic [18:0] rsvd_hi;
        cfg_err_t    err;
        logic [6:0]  rsvd_lo;
        logic        done;
    } mvp_status_t;

endpackage

//--- hdl/mvp_axi_pkg.sv
/*
 * mvp read bus package
 * address and byte count widths, burst geometry and request FIFO sizing
 */
package mvp_axi_pkg;

    localparam int AXI_ADDR_W = 64;
    localparam int XFER_W     = 32;

    // 16 beats of 16 bytes per burst
    localparam int BURST_BEATS = 16;
    localparam int BURST_BYTES = 256;

    // FIFO entries, also the credits held by the generator at reset
    localparam int REQ_FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W     = $clog2(REQ_FIFO_DEPTH);
    localparam int FIFO_CNT_W     = $clog2(REQ_FIFO_DEPTH + 1);

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    // a full 32-bit matrix plus vector region, counted in bursts
    typedef logic [XFER_W-7:0] burst_cnt_t;

endpackage

//--- hdl/mvp_req_if.sv
/*
 * burst request link
 * valid/addr/last forward, one credit pulse back per entry consumed
 */
`timescale 1ns/1ps

interface mvp_req_if import mvp_axi_pkg::*; ();

    logic      valid;
    axi_addr_t addr;
    // final burst of the job
    logic      last;
    logic      credit;

    // generator side, may only send while holding a credit
    modport producer (output valid, output addr, output last, input credit);

    // FIFO write side
    modport buffer_in (input valid, input addr, input last, output credit);

    // FIFO head view
    modport buffer_out (output valid, output addr, output last, input credit);

    // issuer side, credit is the pop
    modport consumer (input valid, input addr, input last, output credit);

endinterface

//--- hdl/mvp_cfg_check.sv
/*
 * job configuration check
 * finds the start edge, registers the five rule errors and
 * issues the job strobe when the job may run
 */
`timescale 1ns/1ps

module mvp_cfg_check import mvp_cfg_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_ap_start,
    input  logic [31:0] i_command,
    input  logic [31:0] i_level,
    input  logic [31:0] i_col_size,
    input  logic [31:0] i_split,
    input  logic [31:0] i_index,
    input  logic [31:0] i_mat_len,
    output logic        o_job_start,
    output cfg_err_t    o_cfg_err
);

    logic        start_d;
    logic        start_pulse;
    logic        pulse_d;
    logic        run_cmd_d;
    logic [15:0] row_size;
    logic [31:0] mat_elems;
    logic [31:0] len_prod;
    logic [31:0] split_prod;
    cfg_err_t    err_next;

    assign start_pulse = i_ap_start & ~start_d;

    // row size is 2^level
    assign row_size   = 16'(1) << i_level[3:0];
    assign mat_elems  = row_size * i_col_size[14:0];
    assign len_prod   = i_mat_len[MAT_LEN_BITS-1:0] * i_index[INDEX_BITS-1:0];
    assign split_prod = i_split[2:0] * row_size;

    ////////////////////////////////////////////////////////////////////
    // rules
    ////////////////////////////////////////////////////////////////////
    assign err_next.level    = (i_level == '0) | (i_level > LEVEL_MAX);
    assign err_next.col_size = (i_col_size == '0) | (i_col_size > COL_SIZE_MAX) |
                               (mat_elems < MIN_MAT_ELEMS);
    assign err_next.split    = (i_split == '0) | (i_split > SPLIT_MAX);
    // one-hot, nothing above the index field
    assign err_next.index    = (i_index[31:INDEX_BITS] != '0) |
                               ($countones(i_index[INDEX_BITS-1:0]) != 1);
    assign err_next.mat_len  = (i_mat_len[31:MAT_LEN_BITS] != '0) |
                               (len_prod != split_prod);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d   <= 1'b0;
            pulse_d   <= 1'b0;
            run_cmd_d <= 1'b0;
            o_cfg_err <= '0;
        end else begin
            start_d <= i_ap_start;
            pulse_d <= start_pulse;
            if (start_pulse) begin
                run_cmd_d <= i_command[0];
                // rules only apply to a run command
                o_cfg_err <= i_command[0] ? err_next : '0;
            end
        end
    end

    // accepted unless a run command failed a rule
    assign o_job_start = pulse_d & (~run_cmd_d | (o_cfg_err == '0));

endmodule

//--- hdl/mvp_burst_gen.sv
/*
 * job state and burst request generator
 * keeps idle, done and the busy cycle count, sizes the two regions
 * and sends one request per burst while credits remain
 */
`timescale 1ns/1ps

module mvp_burst_gen import mvp_cfg_pkg::*, mvp_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_job_start,
    input  cfg_err_t    i_cfg_err,
    input  logic [31:0] i_mat_len,
    input  logic [31:0] i_split,
    input  axi_addr_t   i_mat_ptr,
    input  axi_addr_t   i_vec_ptr,
    input  logic        i_all_returned,
    output mvp_status_t o_status,
    output logic        o_ap_idle,
    output logic [31:0] o_cycle_cnt,
    mvp_req_if.producer req
);

    logic [XFER_W-1:0]     mat_bytes;
    logic [XFER_W-1:0]     vec_bytes;
    logic [XFER_W-1:0]     mat_rem;
    logic [XFER_W-1:0]     vec_rem;
    logic [XFER_W:0]       left_sum;
    axi_addr_t             mat_addr;
    axi_addr_t             vec_addr;
    logic [FIFO_CNT_W-1:0] credits;
    logic                  done_r;
    logic                  in_mat;

    assign mat_bytes = i_mat_len * MAT_BYTES_PER_LEN;
    assign vec_bytes = i_split * VEC_BYTES_PER_SPLIT;

    ////////////////////////////////////////////////////////////////////
    // host handshake
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ap_idle   <= 1'b1;
            done_r      <= 1'b0;
            o_cycle_cnt <= '0;
        end else begin
            if (!o_ap_idle)
                o_cycle_cnt <= o_cycle_cnt + 1'b1;
            if (i_job_start) begin
                o_ap_idle <= 1'b0;
                done_r    <= 1'b0;
            end else if (i_all_returned) begin
                o_ap_idle <= 1'b1;
                done_r    <= 1'b1;
            // rejected job finishes at once
            end else if (i_cfg_err != '0) begin
                done_r <= 1'b1;
            end
        end
    end

    always_comb begin
        o_status      = '0;
        o_status.done = done_r;
        o_status.err  = i_cfg_err;
    end

    ////////////////////////////////////////////////////////////////////
    // region walk, matrix first
    ////////////////////////////////////////////////////////////////////
    assign in_mat    = (mat_rem != '0);
    assign left_sum  = mat_rem + vec_rem;
    assign req.valid = (left_sum != '0) & (credits != '0);
    assign req.addr  = in_mat ? mat_addr : vec_addr;
    assign req.last  = (left_sum == BURST_BYTES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mat_rem <= '0;
            vec_rem <= '0;
            credits <= FIFO_CNT_W'(REQ_FIFO_DEPTH);
        end else begin
            // one spent per valid, one back per FIFO pop
            credits <= credits - req.valid + req.credit;
            if (i_job_start) begin
                mat_rem <= mat_bytes;
                vec_rem <= vec_bytes;
            end else if (req.valid && in_mat) begin
                mat_rem <= mat_rem - BURST_BYTES;
            end else if (req.valid) begin
                vec_rem <= vec_rem - BURST_BYTES;
            end
        end
    end

    // burst addresses
    always_ff @(posedge clk) begin
        if (i_job_start) begin
            mat_addr <= i_mat_ptr;
            vec_addr <= i_vec_ptr;
        end else if (req.valid && in_mat) begin
            mat_addr <= mat_addr + BURST_BYTES;
        end else if (req.valid) begin
            vec_addr <= vec_addr + BURST_BYTES;
        end
    end

    // returned credits never outnumber FIFO entries
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= REQ_FIFO_DEPTH);

endmodule

//--- hdl/mvp_req_fifo.sv
/*
 * burst request FIFO
 * circular buffer of address and last tag, each pop returns a credit
 */
`timescale 1ns/1ps

module mvp_req_fifo import mvp_axi_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    mvp_req_if.buffer_in  wr,
    mvp_req_if.buffer_out rd
);

    axi_addr_t             mem_addr [REQ_FIFO_DEPTH];
    logic                  mem_last [REQ_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;
    logic                  credit_r;

    assign push = wr.valid;
    assign pop  = rd.credit & (count != '0);

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_addr[wr_ptr] <= wr.addr;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_r <= 1'b0;
        end else begin
            credit_r <= pop;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // head view and credit return
    ////////////////////////////////////////////////////////////////////
    assign rd.valid  = (count != '0);
    assign rd.addr   = mem_addr[rd_ptr];
    assign rd.last   = mem_last[rd_ptr];
    assign wr.credit = credit_r;

    // generator credits keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != FIFO_CNT_W'(REQ_FIFO_DEPTH)));

endmodule

//--- hdl/mvp_ar_issuer.sv
/*
 * AR channel issuer
 * presents FIFO head entries as read bursts and tracks the bursts
 * in flight to find the end of the job
 */
`timescale 1ns/1ps

module mvp_ar_issuer import mvp_axi_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    mvp_req_if.consumer req,
    output logic       o_arvalid,
    input  logic       i_arready,
    output axi_addr_t  o_araddr,
    output logic [7:0] o_arlen,
    input  logic       i_rvalid,
    input  logic       i_rlast,
    output logic       o_all_returned
);

    logic       take;
    logic       ar_hs;
    logic       beat_last;
    logic       tag_last;
    logic       last_seen;
    logic       job_end;
    burst_cnt_t outstanding;

    // slot free when empty or handing over this cycle
    assign take        = req.valid & (~o_arvalid | i_arready);
    assign req.credit  = take;
    assign ar_hs       = o_arvalid & i_arready;
    assign beat_last   = i_rvalid & i_rlast;
    assign job_end     = last_seen & (outstanding == '0);
    assign o_arlen     = 8'(BURST_BEATS - 1);

    // request payload
    always_ff @(posedge clk) begin
        if (take) begin
            o_araddr <= req.addr;
            tag_last <= req.last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_arvalid      <= 1'b0;
            outstanding    <= '0;
            last_seen      <= 1'b0;
            o_all_returned <= 1'b0;
        end else begin
            if (take)
                o_arvalid <= 1'b1;
            else if (i_arready)
                o_arvalid <= 1'b0;
            // bursts in flight
            case ({ar_hs, beat_last})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
            // final burst has gone out
            if (ar_hs && tag_last)
                last_seen <= 1'b1;
            else if (job_end)
                last_seen <= 1'b0;
            o_all_returned <= job_end;
        end
    end

    // AR request held until accepted
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)));

endmodule

//--- hdl/mvp_front_top.sv
/*
 * mvp job front end
 * config check, burst generator, request FIFO and AR issuer
 */
`timescale 1ns/1ps

module mvp_front_top import mvp_cfg_pkg::*, mvp_axi_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_ap_start,
    input  logic [31:0] i_command,
    input  logic [31:0] i_level,
    input  logic [31:0] i_col_size,
    input  logic [31:0] i_split,
    input  logic [31:0] i_index,
    input  logic [31:0] i_mat_len,
    input  axi_addr_t   i_mat_ptr,
    input  axi_addr_t   i_vec_ptr,
    output logic [31:0] o_ap_done,
    output logic        o_ap_idle,
    output logic        o_ap_ready,
    output logic [31:0] o_cycle_cnt,
    output logic        o_arvalid,
    input  logic        i_arready,
    output axi_addr_t   o_araddr,
    output logic [7:0]  o_arlen,
    input  logic        i_rvalid,
    input  logic        i_rlast
);

    logic        job_start;
    logic        all_returned;
    cfg_err_t    cfg_err;
    mvp_status_t status;

    mvp_req_if gen_to_fifo ();
    mvp_req_if fifo_to_iss ();

    assign o_ap_done  = status;
    assign o_ap_ready = status.done;

    mvp_cfg_check u_cfg_check (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ap_start  (i_ap_start),
        .i_command   (i_command),
        .i_level     (i_level),
        .i_col_size  (i_col_size),
        .i_split     (i_split),
        .i_index     (i_index),
        .i_mat_len   (i_mat_len),
        .o_job_start (job_start),
        .o_cfg_err   (cfg_err)
    );

    mvp_burst_gen u_burst_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_job_start    (job_start),
        .i_cfg_err      (cfg_err),
        .i_mat_len      (i_mat_len),
        .i_split        (i_split),
        .i_mat_ptr      (i_mat_ptr),
        .i_vec_ptr      (i_vec_ptr),
        .i_all_returned (all_returned),
        .o_status       (status),
        .o_ap_idle      (o_ap_idle),
        .o_cycle_cnt    (o_cycle_cnt),
        .req            (gen_to_fifo.producer)
    );

    mvp_req_fifo u_req_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (gen_to_fifo.buffer_in),
        .rd    (fifo_to_iss.buffer_out)
    );

    mvp_ar_issuer u_ar_issuer (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (fifo_to_iss.consumer),
        .o_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .o_araddr       (o_araddr),
        .o_arlen        (o_arlen),
        .i_rvalid       (i_rvalid),
        .i_rlast        (i_rlast),
        .o_all_returned (all_returned)
    );

endmodule

//--- bench/tb_mvp_tasks.svh
/*
 * directed tests for the mvp front end testbench
 * value compare, job start, run and reject sequences
 */
`ifndef TB_MVP_TASKS_SVH
`define TB_MVP_TASKS_SVH

// stops the run at the first mismatch
task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
        $display("Error: %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        $display("Errors found");
        $fatal(1);
    end
endtask

// one-cycle start pulse that returns at the edge sampling it
task automatic start_job(input logic [31:0] cmd, input logic [31:0] lvl,
                         input logic [31:0] col, input logic [31:0] spl,
                         input logic [31:0] idx, input logic [31:0] len);
    @(posedge clk);
    i_command  <= cmd;
    i_level    <= lvl;
    i_col_size <= col;
    i_split    <= spl;
    i_index    <= idx;
    i_mat_len  <= len;
    i_ap_start <= 1'b1;
    @(posedge clk);
    i_ap_start <= 1'b0;
endtask

task automatic check_reset_state();
    check(o_ap_idle, 1'b1, "idle after reset");
    check(o_ap_done, 32'h0, "done word after reset");
    check(o_arvalid, 1'b0, "arvalid after reset");
    check(o_cycle_cnt, 32'h0, "cycle count after reset");
endtask

//////////////////////////////////////////////////////////////////////
// accepted job with matrix bursts before vector bursts
//////////////////////////////////////////////////////////////////////
task automatic run_job(input logic [31:0] cmd, input logic [31:0] lvl,
                       input logic [31:0] col, input logic [31:0] spl,
                       input logic [31:0] idx, input logic [31:0] len);
    int n_mat;
    int n_vec;
    int target;
    n_mat = int'((len * MAT_BYTES_PER_LEN) / BURST_BYTES);
    n_vec = int'((spl * VEC_BYTES_PER_SPLIT) / BURST_BYTES);
    for (int n = 0; n < n_mat; n++)
        exp_addr.push_back(MAT_BASE + axi_addr_t'(n * BURST_BYTES));
    for (int n = 0; n < n_vec; n++)
        exp_addr.push_back(VEC_BASE + axi_addr_t'(n * BURST_BYTES));
    target = rlast_cnt + n_mat + n_vec;
    start_job(cmd, lvl, col, spl, idx, len);
    @(posedge clk);
    @(negedge clk);
    // busy until the final beat is in
    while (rlast_cnt < target) begin
        check(o_ap_idle, 1'b0, "idle before the final beat");
        check(o_ap_done[0], 1'b0, "done before the final beat");
        @(negedge clk);
    end
    // both stay low for two more edges
    repeat (2) begin
        check(o_ap_idle, 1'b0, "idle early after the final beat");
        check(o_ap_done[0], 1'b0, "done early after the final beat");
        @(negedge clk);
    end
    check(o_ap_idle, 1'b1, "idle two edges after the final beat");
    check(o_ap_done, 32'h1, "done word at job end");
    check(exp_addr.size(), 0, "bursts never issued");
endtask

// run command breaking a rule ends at once with no bursts
task automatic reject_job(input logic [31:0] lvl, input logic [31:0] col,
                          input logic [31:0] spl, input logic [31:0] idx,
                          input logic [31:0] len, input logic [4:0] exp_err);
    start_job(32'd1, lvl, col, spl, idx, len);
    @(posedge clk);
    @(negedge clk);
    check(o_ap_done, {19'd0, exp_err, 7'd0, 1'b1}, "status of rejected job");
    check(o_ap_ready, 1'b1, "ready of rejected job");
    repeat (4) begin
        check(o_ap_idle, 1'b1, "idle during rejected job");
        check(o_arvalid, 1'b0, "arvalid during rejected job");
        @(negedge clk);
    end
endtask

task automatic check_cycle_count();
    check(o_cycle_cnt, busy_cycles, "busy cycle count");
endtask

`endif

//--- bench/tb_mvp_front.sv
/*
 * testbench for the mvp job front end
 * clock, reset, read responder with random back-pressure,
 * AR address scoreboard, watchdog and the directed test sequence
 */
`timescale 1ns/1ps

module tb_mvp_front import mvp_cfg_pkg::*, mvp_axi_pkg::*; ();

    localparam int        CLK_PERIOD = 8;
    localparam axi_addr_t MAT_BASE   = 64'h0000_0010_0000_0000;
    localparam axi_addr_t VEC_BASE   = 64'h0000_0020_0040_0000;
    // bursts of the two legal jobs and the vector-only job
    localparam int        WD_BURSTS  = 384 + 768 + 384 + 768 + 768;
    localparam int        WD_CYCLES  = WD_BURSTS * (BURST_BEATS + 8) + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        i_ap_start;
    logic [31:0] i_command;
    logic [31:0] i_level;
    logic [31:0] i_col_size;
    logic [31:0] i_split;
    logic [31:0] i_index;
    logic [31:0] i_mat_len;
    axi_addr_t   i_mat_ptr;
    axi_addr_t   i_vec_ptr;
    logic [31:0] o_ap_done;
    logic        o_ap_idle;
    logic        o_ap_ready;
    logic [31:0] o_cycle_cnt;
    logic        o_arvalid;
    logic        i_arready;
    axi_addr_t   o_araddr;
    logic [7:0]  o_arlen;
    logic        i_rvalid;
    logic        i_rlast;

    // scoreboard and responder state
    axi_addr_t   exp_addr [$];
    int          busy_cycles = 0;
    int          rlast_cnt   = 0;
    int          pending     = 0;
    int          beat_idx    = 0;
    bit          rand_mode   = 1'b0;
    logic [31:0] lfsr        = 32'h0427d288;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mvp_front_top u_mvp_front_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ap_start  (i_ap_start),
        .i_command   (i_command),
        .i_level     (i_level),
        .i_col_size  (i_col_size),
        .i_split     (i_split),
        .i_index     (i_index),
        .i_mat_len   (i_mat_len),
        .i_mat_ptr   (i_mat_ptr),
        .i_vec_ptr   (i_vec_ptr),
        .o_ap_done   (o_ap_done),
        .o_ap_idle   (o_ap_idle),
        .o_ap_ready  (o_ap_ready),
        .o_cycle_cnt (o_cycle_cnt),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .o_araddr    (o_araddr),
        .o_arlen     (o_arlen),
        .i_rvalid    (i_rvalid),
        .i_rlast     (i_rlast)
    );

    `include "tb_mvp_tasks.svh"

    // galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // AR scoreboard and read responder
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : responder
        logic g0;
        logic gap;
        if (!rst_n) begin
            i_arready <= 1'b0;
            i_rvalid  <= 1'b0;
            i_rlast   <= 1'b0;
        end else begin
            if (!o_ap_idle)
                busy_cycles++;
            if (i_rvalid && i_rlast)
                rlast_cnt++;
            if (o_arvalid && i_arready) begin
                check(o_arlen, BURST_BEATS - 1, "arlen");
                if (exp_addr.size() == 0)
                    check(0, 1, "AR request beyond the expected bursts");
                else
                    check(o_araddr, exp_addr.pop_front(), "araddr");
                pending++;
            end
            // one bit for arready and two for the beat gap
            gap = 1'b0;
            if (rand_mode) begin
                lfsr = lfsr_next(lfsr);
                i_arready <= lfsr[0];
                lfsr = lfsr_next(lfsr);
                g0 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                gap = g0 & lfsr[0];
            end else begin
                i_arready <= 1'b1;
            end
            if (pending > 0 && !gap) begin
                i_rvalid <= 1'b1;
                i_rlast  <= (beat_idx == BURST_BEATS - 1);
                if (beat_idx == BURST_BEATS - 1) begin
                    beat_idx = 0;
                    pending--;
                end else begin
                    beat_idx++;
                end
            end else begin
                i_rvalid <= 1'b0;
                i_rlast  <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not end within %0d cycles", WD_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rst_n      <= 1'b0;
        i_ap_start <= 1'b0;
        i_command  <= '0;
        i_level    <= '0;
        i_col_size <= '0;
        i_split    <= '0;
        i_index    <= '0;
        i_mat_len  <= '0;
        i_mat_ptr  <= MAT_BASE;
        i_vec_ptr  <= VEC_BASE;
        i_arready  <= 1'b0;
        i_rvalid   <= 1'b0;
        i_rlast    <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        // one broken rule per job, the first one seen with done still low
        reject_job(32'd0, 32'd8192, 32'd1, 32'd1, 32'd1, 5'b00001);
        reject_job(32'd1, 32'd2048, 32'd1, 32'd2, 32'd1, 5'b00010);
        reject_job(32'd1, 32'd8192, 32'd5, 32'd2, 32'd5, 5'b00100);
        reject_job(32'd1, 32'd8192, 32'd3, 32'd3, 32'd2, 5'b01000);
        reject_job(32'd1, 32'd8192, 32'd1, 32'd2, 32'd2, 5'b10000);
        // legal job with ready held high
        run_job(32'd1, 32'd1, 32'd8192, 32'd1, 32'd2, 32'd1);
        // same job under back-pressure
        rand_mode = 1'b1;
        run_job(32'd1, 32'd1, 32'd8192, 32'd1, 32'd2, 32'd1);
        // rules off for a vector-only job
        run_job(32'd0, 32'd0, 32'd0, 32'd1, 32'd3, 32'd0);
        check_cycle_count();
        $display("No errors");
        $finish;
    end

endmodule

//--- list.f
+incdir+bench
hdl/mvp_cfg_pkg.sv
hdl/mvp_axi_pkg.sv
hdl/mvp_req_if.sv
hdl/mvp_cfg_check.sv
hdl/mvp_burst_gen.sv
hdl/mvp_req_fifo.sv
hdl/mvp_ar_issuer.sv
hdl/mvp_front_top.sv
bench/tb_mvp_front.sv

//--- Makefile
# Verilator simulation of the mvp job front end

VERILATOR ?= verilator
TOP       ?= tb_mvp_front
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "No errors" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
